// ==== dyn_pkg.sv ====
package dyn_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int VADDR_BITS     = 28;
  localparam int PADDR_BITS     = 28;
  localparam int PAGE_BITS      = 12;
  localparam int TLB_IDX_BITS   = 4;
  localparam int TLB_ENTRIES    = 16;
  localparam int TAG_BITS       = 12;
  localparam int PPN_BITS       = 16;
  localparam int LEN_BITS       = 16;
  localparam int CTRL_ADDR_BITS = 8;
  localparam int CTRL_DATA_BITS = 32;
  localparam int XDMA_CTL_BITS  = 16;

  // --------------------
  // Control address map
  // --------------------
  // Table entries at word addresses 0x00..0x0F
  localparam logic [CTRL_ADDR_BITS-1:0] CTRL_TLB_BASE   = 8'h00;
  localparam logic [CTRL_ADDR_BITS-1:0] CTRL_FAULT_ADDR = 8'h40;
  localparam logic [CTRL_ADDR_BITS-1:0] CTRL_STATUS     = 8'h41;

  typedef enum logic [1:0] {
    TGT_TLB,
    TGT_FAULT,
    TGT_STATUS,
    TGT_NONE
  } ctrl_target_e;

  // Read is host to card, write is card to host
  typedef enum logic {
    DMA_RD = 1'b0,
    DMA_WR = 1'b1
  } dma_dir_e;

  typedef struct packed {
    logic                      wr;
    logic                      rd;
    logic [CTRL_ADDR_BITS-1:0] addr;
    logic [CTRL_DATA_BITS-1:0] wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic                      valid;
    logic [CTRL_DATA_BITS-1:0] rdata;
  } ctrl_rsp_t;

  typedef struct packed {
    logic                  valid;
    dma_dir_e              dir;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
    logic                  ctl;
  } dma_req_t;

  typedef struct packed {
    logic                     h2c_valid;
    logic                     c2h_valid;
    logic [PADDR_BITS-1:0]    addr;
    logic [LEN_BITS-1:0]      len;
    logic [XDMA_CTL_BITS-1:0] ctl_word;
  } xdma_req_t;

  // Field order gives valid at bit 28, tag at 27:16, ppn at 15:0
  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
    logic [PPN_BITS-1:0] ppn;
  } tlb_entry_t;

endpackage

// ==== ctrl_decoder.sv ====
`timescale 1ns/1ps

module ctrl_decoder (
  input  logic                                aclk,
  input  logic                                arst_n,
  input  dyn_pkg::ctrl_req_t                  ctrl_req,
  output dyn_pkg::ctrl_rsp_t                  ctrl_rsp,
  output logic                                tlb_wr,
  output logic                                tlb_rd,
  output logic [dyn_pkg::TLB_IDX_BITS-1:0]    tlb_idx,
  output dyn_pkg::tlb_entry_t                 tlb_wdata,
  input  dyn_pkg::tlb_entry_t                 tlb_rdata,
  output logic                                fault_clear,
  input  logic [dyn_pkg::VADDR_BITS-1:0]      fault_vaddr,
  input  logic                                fault_pending
);

  dyn_pkg::ctrl_target_e               target;
  dyn_pkg::ctrl_target_e               rd_target_q;
  logic                                rd_valid_q;
  logic [dyn_pkg::CTRL_DATA_BITS-1:0]  fault_rdata_q;

  // --------------------
  // Address decode
  // --------------------
  always_comb begin
    if (ctrl_req.addr[dyn_pkg::CTRL_ADDR_BITS-1:dyn_pkg::TLB_IDX_BITS] ==
        dyn_pkg::CTRL_TLB_BASE[dyn_pkg::CTRL_ADDR_BITS-1:dyn_pkg::TLB_IDX_BITS]) begin
      target = dyn_pkg::TGT_TLB;
    end else if (ctrl_req.addr == dyn_pkg::CTRL_FAULT_ADDR) begin
      target = dyn_pkg::TGT_FAULT;
    end else if (ctrl_req.addr == dyn_pkg::CTRL_STATUS) begin
      target = dyn_pkg::TGT_STATUS;
    end else begin
      target = dyn_pkg::TGT_NONE;
    end
  end

  // Table accesses go straight through
  assign tlb_wr    = ctrl_req.wr && (target == dyn_pkg::TGT_TLB);
  assign tlb_rd    = ctrl_req.rd && (target == dyn_pkg::TGT_TLB);
  assign tlb_idx   = ctrl_req.addr[dyn_pkg::TLB_IDX_BITS-1:0];
  assign tlb_wdata = dyn_pkg::tlb_entry_t'(ctrl_req.wdata[$bits(dyn_pkg::tlb_entry_t)-1:0]);

  // Status write with bit 0 set drops the pending flag
  assign fault_clear = ctrl_req.wr && (target == dyn_pkg::TGT_STATUS) && ctrl_req.wdata[0];

  // --------------------
  // Read response
  // --------------------
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid_q  <= 1'b0;
      rd_target_q <= dyn_pkg::TGT_NONE;
    end else begin
      rd_valid_q <= ctrl_req.rd;
      if (ctrl_req.rd) begin
        rd_target_q <= target;
      end
    end
  end

  // Fault side snapshot taken at the read edge
  always_ff @(posedge aclk) begin
    if (ctrl_req.rd) begin
      if (target == dyn_pkg::TGT_FAULT) begin
        fault_rdata_q <= {{(dyn_pkg::CTRL_DATA_BITS-dyn_pkg::VADDR_BITS){1'b0}}, fault_vaddr};
      end else begin
        fault_rdata_q <= {{(dyn_pkg::CTRL_DATA_BITS-1){1'b0}}, fault_pending};
      end
    end
  end

  // Table data is already registered inside the table
  always_comb begin
    ctrl_rsp.valid = rd_valid_q;
    case (rd_target_q)
      dyn_pkg::TGT_TLB: begin
        ctrl_rsp.rdata = {{(dyn_pkg::CTRL_DATA_BITS-$bits(dyn_pkg::tlb_entry_t)){1'b0}},
                          tlb_rdata};
      end
      dyn_pkg::TGT_FAULT, dyn_pkg::TGT_STATUS: begin
        ctrl_rsp.rdata = fault_rdata_q;
      end
      default: begin
        ctrl_rsp.rdata = '0;
      end
    endcase
  end

endmodule

// ==== tlb_table.sv ====
`timescale 1ns/1ps

module tlb_table (
  input  logic                              aclk,
  input  logic                              arst_n,
  // Control port
  input  logic                              wr,
  input  logic                              rd,
  input  logic [dyn_pkg::TLB_IDX_BITS-1:0]  ctrl_idx,
  input  dyn_pkg::tlb_entry_t               wdata,
  output dyn_pkg::tlb_entry_t               rdata,
  // Lookup port
  input  logic [dyn_pkg::TLB_IDX_BITS-1:0]  lookup_idx,
  input  logic [dyn_pkg::TAG_BITS-1:0]      lookup_tag,
  output logic                              hit,
  output logic [dyn_pkg::PPN_BITS-1:0]      ppn
);

  dyn_pkg::tlb_entry_t entries [dyn_pkg::TLB_ENTRIES];
  dyn_pkg::tlb_entry_t lookup_entry;

  // --------------------
  // Entry storage
  // --------------------
  // Every entry clears to invalid on reset
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < dyn_pkg::TLB_ENTRIES; i++) begin
        entries[i] <= '0;
      end
    end else if (wr) begin
      entries[ctrl_idx] <= wdata;
    end
  end

  // Control readback
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (rd) begin
      rdata <= entries[ctrl_idx];
    end
  end

  // --------------------
  // Lookup
  // --------------------
  assign lookup_entry = entries[lookup_idx];

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= lookup_entry.valid && (lookup_entry.tag == lookup_tag);
    end
  end

  // PPN registered alongside hit
  always_ff @(posedge aclk) begin
    ppn <= lookup_entry.ppn;
  end

endmodule

// ==== dma_req_former.sv ====
`timescale 1ns/1ps

module dma_req_former (
  input  logic                              aclk,
  input  logic                              arst_n,
  input  dyn_pkg::dma_req_t                 dma_req,
  output logic [dyn_pkg::TLB_IDX_BITS-1:0]  lookup_idx,
  output logic [dyn_pkg::TAG_BITS-1:0]      lookup_tag,
  input  logic                              hit,
  input  logic [dyn_pkg::PPN_BITS-1:0]      ppn,
  output dyn_pkg::xdma_req_t                xdma_req,
  output logic                              fault_strobe,
  output logic [dyn_pkg::VADDR_BITS-1:0]    fault_vaddr
);

  // Stage one
  logic                                s1_valid;
  dyn_pkg::dma_dir_e                   s1_dir;
  logic [dyn_pkg::VADDR_BITS-1:0]      s1_vaddr;
  logic [dyn_pkg::LEN_BITS-1:0]        s1_len;
  logic                                s1_ctl;

  // Stage two
  logic                                h2c_q;
  logic                                c2h_q;
  logic                                fault_q;
  logic [dyn_pkg::PADDR_BITS-1:0]      addr_q;
  logic [dyn_pkg::LEN_BITS-1:0]        len_q;
  logic [dyn_pkg::XDMA_CTL_BITS-1:0]   ctl_q;
  logic [dyn_pkg::VADDR_BITS-1:0]      vaddr_q;

  // Index from the low VPN bits, tag from the rest
  assign lookup_idx = dma_req.vaddr[dyn_pkg::PAGE_BITS +: dyn_pkg::TLB_IDX_BITS];
  assign lookup_tag = dma_req.vaddr[dyn_pkg::VADDR_BITS-1 -: dyn_pkg::TAG_BITS];

  // --------------------
  // Stage one
  // --------------------
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= dma_req.valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (dma_req.valid) begin
      s1_dir   <= dma_req.dir;
      s1_vaddr <= dma_req.vaddr;
      s1_len   <= dma_req.len;
      s1_ctl   <= dma_req.ctl;
    end
  end

  // --------------------
  // Stage two
  // --------------------
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      h2c_q   <= 1'b0;
      c2h_q   <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      h2c_q   <= s1_valid && hit && (s1_dir == dyn_pkg::DMA_RD);
      c2h_q   <= s1_valid && hit && (s1_dir == dyn_pkg::DMA_WR);
      fault_q <= s1_valid && !hit;
    end
  end

  // Channel control word takes ctl in bits 4, 1 and 0
  always_ff @(posedge aclk) begin
    if (s1_valid) begin
      addr_q  <= {ppn, s1_vaddr[dyn_pkg::PAGE_BITS-1:0]};
      len_q   <= s1_len;
      ctl_q   <= {{(dyn_pkg::XDMA_CTL_BITS-5){1'b0}}, s1_ctl, 2'b00, {2{s1_ctl}}};
      vaddr_q <= s1_vaddr;
    end
  end

  always_comb begin
    xdma_req.h2c_valid = h2c_q;
    xdma_req.c2h_valid = c2h_q;
    xdma_req.addr      = addr_q;
    xdma_req.len       = len_q;
    xdma_req.ctl_word  = ctl_q;
  end

  assign fault_strobe = fault_q;
  assign fault_vaddr  = vaddr_q;

endmodule

// ==== fault_reg.sv ====
`timescale 1ns/1ps

module fault_reg (
  input  logic                            aclk,
  input  logic                            arst_n,
  input  logic                            fault_strobe,
  input  logic [dyn_pkg::VADDR_BITS-1:0]  fault_vaddr_in,
  input  logic                            clear,
  output logic [dyn_pkg::VADDR_BITS-1:0]  fault_vaddr,
  output logic                            pending
);

  // --------------------
  // Pending flag
  // --------------------
  // Clear beats a fault in the same cycle, and that fault is dropped
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
    end else if (clear) begin
      pending <= 1'b0;
    end else if (fault_strobe) begin
      pending <= 1'b1;
    end
  end

  // --------------------
  // Fault address
  // --------------------
  // Only the first miss is kept until software clears it
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      fault_vaddr <= '0;
    end else if (fault_strobe && !pending && !clear) begin
      fault_vaddr <= fault_vaddr_in;
    end
  end

endmodule

// ==== dyn_region_top.sv ====
`timescale 1ns/1ps

module dyn_region_top (
  input  logic                aclk,
  input  logic                arst_n,
  input  dyn_pkg::ctrl_req_t  ctrl_req,
  output dyn_pkg::ctrl_rsp_t  ctrl_rsp,
  input  dyn_pkg::dma_req_t   dma_req,
  output dyn_pkg::xdma_req_t  xdma_req,
  output logic                usr_irq
);

  // Control side
  logic                              tlb_wr;
  logic                              tlb_rd;
  logic [dyn_pkg::TLB_IDX_BITS-1:0]  tlb_idx;
  dyn_pkg::tlb_entry_t               tlb_wdata;
  dyn_pkg::tlb_entry_t               tlb_rdata;
  logic                              fault_clear;
  logic [dyn_pkg::VADDR_BITS-1:0]    fault_vaddr;

  // DMA side
  logic [dyn_pkg::TLB_IDX_BITS-1:0]  lookup_idx;
  logic [dyn_pkg::TAG_BITS-1:0]      lookup_tag;
  logic                              lookup_hit;
  logic [dyn_pkg::PPN_BITS-1:0]      lookup_ppn;
  logic                              fault_strobe;
  logic [dyn_pkg::VADDR_BITS-1:0]    miss_vaddr;

  // --------------------
  // Control decode
  // --------------------
  ctrl_decoder inst_ctrl_decoder (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .ctrl_req      (ctrl_req),
    .ctrl_rsp      (ctrl_rsp),
    .tlb_wr        (tlb_wr),
    .tlb_rd        (tlb_rd),
    .tlb_idx       (tlb_idx),
    .tlb_wdata     (tlb_wdata),
    .tlb_rdata     (tlb_rdata),
    .fault_clear   (fault_clear),
    .fault_vaddr   (fault_vaddr),
    .fault_pending (usr_irq)
  );

  // --------------------
  // Translation table
  // --------------------
  tlb_table inst_tlb_table (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .wr         (tlb_wr),
    .rd         (tlb_rd),
    .ctrl_idx   (tlb_idx),
    .wdata      (tlb_wdata),
    .rdata      (tlb_rdata),
    .lookup_idx (lookup_idx),
    .lookup_tag (lookup_tag),
    .hit        (lookup_hit),
    .ppn        (lookup_ppn)
  );

  // --------------------
  // DMA request path
  // --------------------
  dma_req_former inst_dma_req_former (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .dma_req      (dma_req),
    .lookup_idx   (lookup_idx),
    .lookup_tag   (lookup_tag),
    .hit          (lookup_hit),
    .ppn          (lookup_ppn),
    .xdma_req     (xdma_req),
    .fault_strobe (fault_strobe),
    .fault_vaddr  (miss_vaddr)
  );

  // Pending flag is the region interrupt
  fault_reg inst_fault_reg (
    .aclk           (aclk),
    .arst_n         (arst_n),
    .fault_strobe   (fault_strobe),
    .fault_vaddr_in (miss_vaddr),
    .clear          (fault_clear),
    .fault_vaddr    (fault_vaddr),
    .pending        (usr_irq)
  );

endmodule

// ==== dyn_region_checker.sv ====
`timescale 1ns/1ps

module dyn_region_checker (
  input  logic               aclk,
  input  logic               arst_n,
  input  dyn_pkg::ctrl_req_t ctrl_req,
  input  dyn_pkg::ctrl_rsp_t ctrl_rsp,
  input  dyn_pkg::dma_req_t  dma_req,
  input  dyn_pkg::xdma_req_t xdma_req,
  input  logic               usr_irq,
  output int                 error_count,
  output int                 check_count
);

  int errors = 0;
  int checks = 0;

  // Mirror of the table words and the fault state
  logic [31:0] table_m [16];
  logic [27:0] fault_addr_m;
  logic        pending_m;

  // Expected channel requests for the last two edges
  dyn_pkg::xdma_req_t exp_req   [2];
  logic               exp_fault [2];
  logic [27:0]        exp_vaddr [2];

  logic               rd_pending;
  logic [31:0]        rd_expect;
  logic               clear_now;
  dyn_pkg::xdma_req_t next_req;

  assign error_count = errors;
  assign check_count = checks;

  // --------------------
  // Reference model
  // --------------------
  // Entry word has valid in bit 28, tag in 27:16, PPN in 15:0
  function automatic dyn_pkg::xdma_req_t expected_xdma(input dyn_pkg::dma_req_t req,
                                                       input logic [31:0] word);
    dyn_pkg::xdma_req_t x;
    x = '0;
    if (req.valid && word[28] && (word[27:16] == req.vaddr[27:16])) begin
      x.h2c_valid   = (req.dir == dyn_pkg::DMA_RD);
      x.c2h_valid   = (req.dir == dyn_pkg::DMA_WR);
      x.addr        = {word[15:0], req.vaddr[11:0]};
      x.len         = req.len;
      x.ctl_word[0] = req.ctl;
      x.ctl_word[1] = req.ctl;
      x.ctl_word[4] = req.ctl;
    end
    return x;
  endfunction

  function automatic logic [31:0] read_ref(input logic [7:0] addr);
    if (addr < 8'h10) begin
      return table_m[addr[3:0]];
    end else if (addr == dyn_pkg::CTRL_FAULT_ADDR) begin
      return {4'h0, fault_addr_m};
    end else if (addr == dyn_pkg::CTRL_STATUS) begin
      return {31'h0, pending_m};
    end
    return '0;
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
    end
  endtask

  // --------------------
  // Watch and compare
  // --------------------
  always @(posedge aclk) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        table_m[i] = '0;
      end
      fault_addr_m = '0;
      pending_m    = 1'b0;
      rd_pending   = 1'b0;
      rd_expect    = '0;
      for (int i = 0; i < 2; i++) begin
        exp_req[i]   = '0;
        exp_fault[i] = 1'b0;
        exp_vaddr[i] = '0;
      end
    end else begin
      // Request seen two edges ago
      compare("h2c_valid", 64'(xdma_req.h2c_valid), 64'(exp_req[1].h2c_valid));
      compare("c2h_valid", 64'(xdma_req.c2h_valid), 64'(exp_req[1].c2h_valid));
      if (exp_req[1].h2c_valid || exp_req[1].c2h_valid) begin
        compare("channel addr", 64'(xdma_req.addr), 64'(exp_req[1].addr));
        compare("channel len", 64'(xdma_req.len), 64'(exp_req[1].len));
        compare("channel ctl_word", 64'(xdma_req.ctl_word), 64'(exp_req[1].ctl_word));
      end

      // Read data one edge after the strobe
      compare("response valid", 64'(ctrl_rsp.valid), 64'(rd_pending));
      if (rd_pending) begin
        compare("response rdata", 64'(ctrl_rsp.rdata), 64'(rd_expect));
      end
      compare("usr_irq", 64'(usr_irq), 64'(pending_m));

      // Reads see the state from before this edge
      rd_pending = ctrl_req.rd;
      if (ctrl_req.rd) begin
        rd_expect = read_ref(ctrl_req.addr);
      end

      // Clear wins over a fault on the same edge
      clear_now = ctrl_req.wr && (ctrl_req.addr == dyn_pkg::CTRL_STATUS) && ctrl_req.wdata[0];
      if (clear_now) begin
        pending_m = 1'b0;
      end else if (exp_fault[1] && !pending_m) begin
        pending_m    = 1'b1;
        fault_addr_m = exp_vaddr[1];
      end

      // Lookup sees the table before a write on this edge
      next_req     = expected_xdma(dma_req, table_m[dma_req.vaddr[15:12]]);
      exp_req[1]   = exp_req[0];
      exp_fault[1] = exp_fault[0];
      exp_vaddr[1] = exp_vaddr[0];
      exp_req[0]   = next_req;
      exp_fault[0] = dma_req.valid && !(next_req.h2c_valid || next_req.c2h_valid);
      exp_vaddr[0] = dma_req.vaddr;

      if (ctrl_req.wr && (ctrl_req.addr < 8'h10)) begin
        table_m[ctrl_req.addr[3:0]] = ctrl_req.wdata & 32'h1FFF_FFFF;
      end
    end
  end

endmodule

// ==== tb_dyn_region.sv ====
`timescale 1ns/1ps

module tb_dyn_region;

  // Roughly 800 cycles of stimulus plus margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic               aclk;
  logic               arst_n;
  dyn_pkg::ctrl_req_t ctrl_req;
  dyn_pkg::ctrl_rsp_t ctrl_rsp;
  dyn_pkg::dma_req_t  dma_req;
  dyn_pkg::xdma_req_t xdma_req;
  logic               usr_irq;
  int                 error_count;
  int                 check_count;
  int                 cycle_count = 0;

  // Tags of the pages currently mapped
  logic [11:0] page_tag [16];

  dyn_region_top uut (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .ctrl_req (ctrl_req),
    .ctrl_rsp (ctrl_rsp),
    .dma_req  (dma_req),
    .xdma_req (xdma_req),
    .usr_irq  (usr_irq)
  );

  dyn_region_checker chk (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .ctrl_req    (ctrl_req),
    .ctrl_rsp    (ctrl_rsp),
    .dma_req     (dma_req),
    .xdma_req    (xdma_req),
    .usr_irq     (usr_irq),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------
  // Bus helpers
  // --------------------
  function automatic dyn_pkg::ctrl_req_t ctrl_op(input logic wr, input logic rd,
                                                 input logic [7:0] addr, input logic [31:0] wdata);
    dyn_pkg::ctrl_req_t c;
    c.wr    = wr;
    c.rd    = rd;
    c.addr  = addr;
    c.wdata = wdata;
    return c;
  endfunction

  // Random direction, length and ctl
  function automatic dyn_pkg::dma_req_t dma_op(input logic [27:0] vaddr);
    dyn_pkg::dma_req_t d;
    d.valid = 1'b1;
    d.dir   = ($urandom % 2 == 0) ? dyn_pkg::DMA_RD : dyn_pkg::DMA_WR;
    d.vaddr = vaddr;
    d.len   = 16'($urandom);
    d.ctl   = 1'($urandom);
    return d;
  endfunction

  function automatic logic [27:0] mapped_vaddr(input int idx);
    return {page_tag[idx], 4'(idx), 12'($urandom)};
  endfunction

  function automatic logic [7:0] unmapped_addr();
    if ($urandom % 2 == 0) begin
      return 8'(8'h10 + $urandom % 8'h30);
    end
    return 8'(8'h42 + $urandom % 8'hBE);
  endfunction

  task automatic drive(input dyn_pkg::ctrl_req_t c, input dyn_pkg::dma_req_t d);
    @(negedge aclk);
    ctrl_req = c;
    dma_req  = d;
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0, '0);
  endtask

  task automatic ctrl_write(input logic [7:0] addr, input logic [31:0] wdata);
    drive(ctrl_op(1'b1, 1'b0, addr, wdata), '0);
  endtask

  task automatic ctrl_read(input logic [7:0] addr);
    drive(ctrl_op(1'b0, 1'b1, addr, '0), '0);
  endtask

  task automatic map_page(input int idx);
    logic [15:0] ppn;
    ppn           = 16'($urandom);
    page_tag[idx] = 12'($urandom);
    ctrl_write(8'(idx), {4'b0001, page_tag[idx], ppn});
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    dyn_pkg::ctrl_req_t c;
    dyn_pkg::dma_req_t  d;
    int                 widx;
    int                 last_widx;
    void'($urandom(36));
    arst_n    = 1'b0;
    ctrl_req  = '0;
    dma_req   = '0;
    last_widx = 0;
    repeat (16) @(negedge aclk);
    arst_n = 1'b1;
    idle(2);

    // Reset contents
    for (int i = 0; i < 16; i++) begin
      ctrl_read(8'(i));
    end
    ctrl_read(dyn_pkg::CTRL_FAULT_ADDR);
    ctrl_read(dyn_pkg::CTRL_STATUS);

    // Random table traffic mixed with unmapped and read-only accesses
    ctrl_write(dyn_pkg::CTRL_FAULT_ADDR, $urandom);
    ctrl_read(dyn_pkg::CTRL_FAULT_ADDR);
    for (int i = 0; i < 48; i++) begin
      case ($urandom % 4)
        0: ctrl_write(unmapped_addr(), $urandom);
        1: ctrl_read(unmapped_addr());
        2: ctrl_read(8'($urandom % 16));
        default: ctrl_write(8'($urandom % 16), $urandom);
      endcase
    end
    for (int i = 0; i < 16; i++) begin
      ctrl_read(8'(i));
    end

    // Translated requests to mapped pages
    for (int i = 0; i < 16; i++) begin
      map_page(i);
    end
    for (int i = 0; i < 200; i++) begin
      drive('0, dma_op(mapped_vaddr(int'($urandom % 16))));
      if ($urandom % 2 == 0) begin
        idle(1);
      end
    end
    idle(3);

    // Invalid entry first, then a tag mismatch that must not overwrite
    ctrl_write(8'd5, 32'h0);
    drive('0, dma_op(mapped_vaddr(5)));
    drive('0, dma_op({~page_tag[3], 4'd3, 12'($urandom)}));
    idle(4);
    ctrl_read(dyn_pkg::CTRL_FAULT_ADDR);
    ctrl_read(dyn_pkg::CTRL_STATUS);
    drive('0, dma_op(mapped_vaddr(7)));
    idle(3);

    // Clear, then capture the next miss
    ctrl_write(dyn_pkg::CTRL_STATUS, 32'h1);
    idle(2);
    ctrl_read(dyn_pkg::CTRL_STATUS);
    drive('0, dma_op({~page_tag[3], 4'd3, 12'($urandom)}));
    idle(4);
    ctrl_read(dyn_pkg::CTRL_FAULT_ADDR);
    ctrl_read(dyn_pkg::CTRL_STATUS);

    // Miss strobe on the same edge as a clear while nothing is pending
    ctrl_write(dyn_pkg::CTRL_STATUS, 32'h1);
    drive('0, dma_op(mapped_vaddr(5)));
    idle(1);
    ctrl_write(dyn_pkg::CTRL_STATUS, 32'h1);
    idle(3);
    ctrl_read(dyn_pkg::CTRL_FAULT_ADDR);
    ctrl_read(dyn_pkg::CTRL_STATUS);

    // Back to back with table rewrites in the same and following cycles
    for (int i = 0; i < 300; i++) begin
      widx = ($urandom % 2 == 0) ? last_widx : int'($urandom % 16);
      if ($urandom % 8 == 0) begin
        d = dma_op(28'($urandom));
      end else begin
        d = dma_op(mapped_vaddr(widx));
      end
      c = '0;
      if ($urandom % 4 == 0) begin
        widx = int'($urandom % 16);
        if ($urandom % 2 == 0) begin
          page_tag[widx] = 12'($urandom);
        end
        c = ctrl_op(1'b1, 1'b0, 8'(widx), {4'b0001, page_tag[widx], 16'($urandom)});
        last_widx = widx;
      end
      drive(c, d);
    end
    ctrl_write(dyn_pkg::CTRL_STATUS, 32'h1);
    idle(2);
    ctrl_read(dyn_pkg::CTRL_STATUS);
    idle(4);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
dyn_pkg.sv
ctrl_decoder.sv
tlb_table.sv
dma_req_former.sv
fault_reg.sv
dyn_region_top.sv
dyn_region_checker.sv
tb_dyn_region.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dynamic region testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_dyn_region
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
